/* Bender.yml */
package:
  name: snow_cache

sources:
  - files:
      - source/snow_pkg.sv
      - source/tlb_array.sv
      - source/cache_array.sv
      - source/miss_controller.sv
      - source/snow_cache_top.sv
  - target: simulation
    files:
      - verif/snow_mem_model.sv
      - verif/snow_cache_tb.sv

/* snow_cache_top.f */
source/snow_pkg.sv
source/tlb_array.sv
source/cache_array.sv
source/miss_controller.sv
source/snow_cache_top.sv
verif/snow_mem_model.sv
verif/snow_cache_tb.sv

/* source/cache_array.sv */
module cache_array
  import snow_pkg::*;
(
  input  logic       CPU_CLK,
  input  logic       arst_n,
  input  logic       accept,
  input  cpu_req_t   req,
  input  logic       inhibit,
  input  tlb_rsp_t   tlb_rsp,
  input  fill_t      fill,
  output cache_rsp_t cache_rsp
);

  logic [ctag_w-1:0]     tag_mem  [line_cnt];
  logic [data_w-1:0]     data_mem [line_cnt];
  logic [line_cnt-1:0]   valid_q;

  logic [line_idx_w-1:0] rd_idx;
  logic [line_idx_w-1:0] idx_q;
  logic [tlb_idx_w-1:0]  page_lo_q;   // addr 15:8 of the request
  logic [ctag_w-1:0]     rd_tag;
  logic [data_w-1:0]     rd_data;
  logic                  rd_valid;
  logic                  bypass_q;
  logic [ctag_w-1:0]     cmp_tag;
  logic                  hit;

  assign rd_idx = req.addr[line_idx_w-1:0];

  // ----------------------------------------------------------------------
  // line storage, written only by the controller fill
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (fill.valid)
    begin
      tag_mem[fill.idx]  <= fill.tag;
      data_mem[fill.idx] <= fill.data;
    end
  end

  always_ff @(posedge CPU_CLK or negedge arst_n)
  begin
    if (!arst_n)
      valid_q <= '0;
    else if (fill.valid)
      valid_q[fill.idx] <= 1'b1;
  end

  // ----------------------------------------------------------------------
  // registered read on the accept edge
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      rd_tag    <= tag_mem[rd_idx];
      rd_data   <= data_mem[rd_idx];
      idx_q     <= rd_idx;
      page_lo_q <= req.addr[line_idx_w +: tlb_idx_w];
    end
  end

  always_ff @(posedge CPU_CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_valid <= 1'b0;
      bypass_q <= 1'b0;
    end
    else if (accept)
    begin
      rd_valid <= valid_q[rd_idx];
      bypass_q <= req.force_miss | inhibit;   // read goes to the port anyway
    end
  end

  // tag compare against the translated page, same cycle as the tlb output
  assign cmp_tag   = {tlb_rsp.ptag, page_lo_q};
  assign hit       = rd_valid & (rd_tag == cmp_tag) & ~bypass_q;
  assign cache_rsp = '{hit: hit, data: rd_data};

  // a hit must belong to a line that is marked valid in the vector
  assert property (@(posedge CPU_CLK) disable iff (!arst_n)
                   cache_rsp.hit |-> valid_q[idx_q]);

endmodule

/* source/miss_controller.sv */
module miss_controller
  import snow_pkg::*;
(
  input  logic              CPU_CLK,
  input  logic              arst_n,
  input  logic              accept,
  input  logic              tlb_we,
  input  cpu_req_t          req,
  input  logic              inhibit,
  input  tlb_rsp_t          tlb_rsp,
  input  cache_rsp_t        cache_rsp,
  output logic              cpu_busy,
  output logic              cpu_done,
  output logic              cpu_fault,
  output logic [data_w-1:0] cpu_rdata,
  output fill_t             fill,
  output port_req_t         port_req,
  output logic              mem_valid,
  input  logic              mem_ack,
  input  logic [data_w-1:0] mem_rdata,
  output logic              dma_wrte,
  output logic              dma_read,
  input  logic              dma_wrte_ack,
  input  logic              dma_read_ack,
  input  logic [data_w-1:0] dma_rdata
);

  ctrl_state_t           state;
  cpu_req_t              req_q;
  logic                  tlb_op_q;
  logic                  inhibit_q;

  logic [addr_w-1:0]     phys_addr;
  region_t               region;
  logic                  lookup_fault;
  logic                  lookup_hit;
  logic                  answer_now;
  logic                  go_port;
  logic                  port_ack;
  logic [data_w-1:0]     port_rdata;

  logic                  fill_valid;
  logic [line_idx_w-1:0] fill_idx;
  logic [ctag_w-1:0]     fill_tag;
  logic [data_w-1:0]     fill_data;

  // ----------------------------------------------------------------------
  // lookup decision
  // ----------------------------------------------------------------------
  assign phys_addr = {tlb_rsp.ptag, req_q.addr[line_idx_w +: tlb_idx_w],
                      req_q.addr[line_idx_w-1:0]};
  assign region    = (phys_addr[addr_w-1 -: 2] == dma_region_bits) ? region_dma
                                                                   : region_mem;

  assign lookup_fault = ~tlb_op_q & tlb_rsp.fault;
  assign lookup_hit   = ~tlb_op_q & ~tlb_rsp.fault & ~req_q.we & cache_rsp.hit;
  assign answer_now   = tlb_op_q | tlb_rsp.fault | lookup_hit;
  assign go_port      = (state == st_lookup) & ~answer_now;

  // only the port that was asked can finish the wait
  assign port_ack   = ((state == st_mem_wait) & mem_ack) |
                      ((state == st_dma_wait) & ((dma_wrte & dma_wrte_ack) |
                                                 (dma_read & dma_read_ack)));
  assign port_rdata = (state == st_dma_wait) ? dma_rdata : mem_rdata;

  assign cpu_busy = (state != st_idle);

  // ----------------------------------------------------------------------
  // FSM and port handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= st_idle;
      mem_valid  <= 1'b0;
      dma_wrte   <= 1'b0;
      dma_read   <= 1'b0;
      cpu_done   <= 1'b0;
      cpu_fault  <= 1'b0;
      fill_valid <= 1'b0;
    end
    else
    begin
      cpu_done   <= 1'b0;   // pulses
      cpu_fault  <= 1'b0;
      fill_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          if (accept)
            state <= st_lookup;
        end
        st_lookup:
        begin
          if (answer_now)
          begin
            cpu_done  <= 1'b1;
            cpu_fault <= lookup_fault;
            state     <= st_answer;
          end
          else if (region == region_dma)
          begin
            dma_wrte <= req_q.we;
            dma_read <= ~req_q.we;
            state    <= st_dma_wait;
          end
          else
          begin
            mem_valid <= 1'b1;
            state     <= st_mem_wait;
          end
        end
        st_mem_wait, st_dma_wait:
        begin
          if (port_ack)
          begin
            mem_valid  <= 1'b0;   // drop in the ack cycle
            dma_wrte   <= 1'b0;
            dma_read   <= 1'b0;
            cpu_done   <= 1'b1;
            fill_valid <= req_q.we | ~inhibit_q;   // stores always refresh
            state      <= st_answer;
          end
        end
        st_answer:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // request, port payload, cpu data and fill record
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_q     <= req;
      tlb_op_q  <= tlb_we;
      inhibit_q <= inhibit;
    end
    if (go_port)
      port_req <= '{addr: phys_addr, wdata: req_q.wdata, we: req_q.we};
    if (lookup_hit && state == st_lookup)
      cpu_rdata <= cache_rsp.data;
    else if (port_ack && !req_q.we)
      cpu_rdata <= port_rdata;
    if (port_ack)
    begin
      fill_idx  <= req_q.addr[line_idx_w-1:0];
      fill_tag  <= port_req.addr[addr_w-1 -: ctag_w];   // physical page + 15:8
      fill_data <= req_q.we ? req_q.wdata : port_rdata;
    end
  end

  assign fill = '{valid: fill_valid, idx: fill_idx, tag: fill_tag, data: fill_data};

  // answer to the cpu is a single-cycle pulse
  assert property (@(posedge CPU_CLK) disable iff (!arst_n)
                   cpu_done |=> !cpu_done);

  // at most one port request outstanding
  assert property (@(posedge CPU_CLK) disable iff (!arst_n)
                   $onehot0({mem_valid, dma_wrte, dma_read}));

endmodule

/* source/snow_cache_top.sv */
module snow_cache_top
  import snow_pkg::*;
(
  input  logic              CPU_CLK,
  input  logic              arst_n,
  // cpu side
  input  logic              cpu_valid,
  input  logic              tlb_we,
  input  cpu_req_t          cpu_req,
  input  logic              vmem,
  input  logic              cache_inhibit,
  output logic              cpu_busy,
  output logic              cpu_done,
  output logic              cpu_fault,
  output logic [data_w-1:0] cpu_rdata,
  // memory and dma ports, shared request record
  output port_req_t         port_req,
  output logic              mem_valid,
  input  logic              mem_ack,
  input  logic [data_w-1:0] mem_rdata,
  output logic              dma_wrte,
  output logic              dma_read,
  input  logic              dma_wrte_ack,
  input  logic              dma_read_ack,
  input  logic [data_w-1:0] dma_rdata
);

  logic       accept;
  tlb_rsp_t   tlb_rsp;
  cache_rsp_t cache_rsp;
  fill_t      fill;

  // lookups and tlb writes both start on this edge
  assign accept = (cpu_valid | tlb_we) & ~cpu_busy;

  tlb_array u_tlb
  (
    .CPU_CLK (CPU_CLK),
    .arst_n  (arst_n),
    .accept  (accept),
    .tlb_we  (tlb_we),
    .vmem    (vmem),
    .req     (cpu_req),
    .tlb_rsp (tlb_rsp)
  );

  cache_array u_cache
  (
    .CPU_CLK   (CPU_CLK),
    .arst_n    (arst_n),
    .accept    (accept),
    .req       (cpu_req),
    .inhibit   (cache_inhibit),
    .tlb_rsp   (tlb_rsp),
    .fill      (fill),
    .cache_rsp (cache_rsp)
  );

  miss_controller u_ctrl
  (
    .CPU_CLK      (CPU_CLK),
    .arst_n       (arst_n),
    .accept       (accept),
    .tlb_we       (tlb_we),
    .req          (cpu_req),
    .inhibit      (cache_inhibit),
    .tlb_rsp      (tlb_rsp),
    .cache_rsp    (cache_rsp),
    .cpu_busy     (cpu_busy),
    .cpu_done     (cpu_done),
    .cpu_fault    (cpu_fault),
    .cpu_rdata    (cpu_rdata),
    .fill         (fill),
    .port_req     (port_req),
    .mem_valid    (mem_valid),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .dma_wrte     (dma_wrte),
    .dma_read     (dma_read),
    .dma_wrte_ack (dma_wrte_ack),
    .dma_read_ack (dma_read_ack),
    .dma_rdata    (dma_rdata)
  );

endmodule

/* source/snow_pkg.sv */
package snow_pkg;

  // ----------------------------------------------------------------------
  // widths and sizes
  // ----------------------------------------------------------------------
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int line_idx_w = 8;                     // addr 7:0
  localparam int tlb_idx_w  = 8;                     // addr 15:8
  localparam int vtag_w     = 16;                    // addr 31:16
  localparam int ctag_w     = vtag_w + tlb_idx_w;    // page tag + addr 15:8
  localparam int line_cnt   = 1 << line_idx_w;
  localparam int tlb_cnt    = 1 << tlb_idx_w;

  // physical addr 31:30 of the dma window
  localparam logic [1:0] dma_region_bits = 2'b11;

  // ----------------------------------------------------------------------
  // enums
  // ----------------------------------------------------------------------
  typedef enum logic
  {
    region_mem,   // 00, 01, 10
    region_dma    // 11
  } region_t;

  typedef enum logic [2:0]
  {
    st_idle,
    st_lookup,    // arrays present their read data
    st_mem_wait,
    st_dma_wait,
    st_answer     // cpu_done cycle
  } ctrl_state_t;

  // ----------------------------------------------------------------------
  // records passed between blocks
  // ----------------------------------------------------------------------
  typedef struct packed
  {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              we;
    logic              force_miss;
  } cpu_req_t;

  typedef struct packed
  {
    logic [vtag_w-1:0] ptag;
    logic              fault;
  } tlb_rsp_t;

  typedef struct packed
  {
    logic              hit;
    logic [data_w-1:0] data;
  } cache_rsp_t;

  // line write from the controller
  typedef struct packed
  {
    logic                  valid;
    logic [line_idx_w-1:0] idx;
    logic [ctag_w-1:0]     tag;
    logic [data_w-1:0]     data;
  } fill_t;

  typedef struct packed
  {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              we;
  } port_req_t;

endpackage

/* source/tlb_array.sv */
module tlb_array
  import snow_pkg::*;
(
  input  logic     CPU_CLK,
  input  logic     arst_n,
  input  logic     accept,
  input  logic     tlb_we,
  input  logic     vmem,
  input  cpu_req_t req,
  output tlb_rsp_t tlb_rsp
);

  logic [vtag_w-1:0]    ptag_mem [tlb_cnt];   // physical page tags
  logic [vtag_w-1:0]    vtag_mem [tlb_cnt];   // virtual tags for the fault check

  logic [tlb_idx_w-1:0] idx;
  logic [vtag_w-1:0]    rd_ptag;
  logic [vtag_w-1:0]    rd_vtag;
  logic [vtag_w-1:0]    req_tag_q;
  logic                 vmem_q;
  logic [vtag_w-1:0]    ptag;
  logic                 fault;

  assign idx = req.addr[line_idx_w +: tlb_idx_w];

  // ----------------------------------------------------------------------
  // entry write, wdata 31:16 physical, 15:0 virtual
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept && tlb_we)
    begin
      ptag_mem[idx] <= req.wdata[data_w-1 -: vtag_w];
      vtag_mem[idx] <= req.wdata[vtag_w-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // lookup, registered with the request
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      rd_ptag   <= ptag_mem[idx];
      rd_vtag   <= vtag_mem[idx];
      req_tag_q <= req.addr[addr_w-1 -: vtag_w];
    end
  end

  always_ff @(posedge CPU_CLK or negedge arst_n)
  begin
    if (!arst_n)
      vmem_q <= 1'b0;
    else if (accept)
      vmem_q <= vmem;   // mode held for the whole request
  end

  // identity mapping with translation off
  assign ptag  = vmem_q ? rd_ptag : req_tag_q;
  assign fault = vmem_q & (rd_vtag != req_tag_q);

  assign tlb_rsp = '{ptag: ptag, fault: fault};

  // a fault only comes out of a request accepted with translation on
  assert property (@(posedge CPU_CLK) disable iff (!arst_n)
                   $rose(tlb_rsp.fault) |-> $past(vmem));

endmodule

/* verif/snow_cache_tb.sv */
module snow_cache_tb
  import snow_pkg::*;
();

  localparam int n_iter    = 16;
  localparam int total_req = tlb_cnt + 12 * n_iter;   // tlb load plus six tests

  logic              CPU_CLK;
  logic              arst_n;
  logic              cpu_valid;
  logic              tlb_we;
  cpu_req_t          cpu_req;
  logic              vmem;
  logic              cache_inhibit;
  logic              cpu_busy;
  logic              cpu_done;
  logic              cpu_fault;
  logic [data_w-1:0] cpu_rdata;
  port_req_t         port_req;
  logic              mem_valid;
  logic              mem_ack;
  logic [data_w-1:0] mem_rdata;
  logic              dma_wrte;
  logic              dma_read;
  logic              dma_wrte_ack;
  logic              dma_read_ack;
  logic [data_w-1:0] dma_rdata;
  int                txn_cnt;
  logic [addr_w-1:0] last_addr;
  logic [data_w-1:0] last_wdata;
  logic              last_we;
  logic              last_dma;
  logic              last_dma_we;

  // reference state: tlb contents, cache tags, written memory words
  logic [vtag_w-1:0] tlb_p [tlb_cnt];
  logic [vtag_w-1:0] tlb_v [tlb_cnt];
  logic              c_valid [line_cnt];
  logic [ctag_w-1:0] c_tag [line_cnt];
  logic [data_w-1:0] c_data [line_cnt];
  logic [addr_w-1:0] m_addr [$];
  logic [data_w-1:0] m_data [$];

  string             cur_test;
  int                test_errors;
  int                errors;
  int                tests_run;
  int                tests_failed;
  int                req_count;
  int unsigned       seed;

  snow_cache_top dut0 (.*);
  snow_mem_model port0 (.*);

  always #10 CPU_CLK = ~CPU_CLK;

  function automatic logic [data_w-1:0] init_word(input logic [addr_w-1:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5ac3_e10f;
  endfunction

  function automatic logic [data_w-1:0] stored_word(input logic [addr_w-1:0] a);
    foreach (m_addr[i])
      if (m_addr[i] == a)
        return m_data[i];
    return init_word(a);
  endfunction

  task automatic store_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    foreach (m_addr[i])
    begin
      if (m_addr[i] == a)
      begin
        m_data[i] = d;
        return;
      end
    end
    m_addr.push_back(a);
    m_data.push_back(d);
  endtask

  // with translation off the physical address is the request address
  function automatic logic line_resident(input logic [addr_w-1:0] a);
    return c_valid[a[7:0]] && (c_tag[a[7:0]] == a[31:8]);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0)
      $display("test %s passed", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // one request: predict, drive, wait for cpu_done, compare, update model
  // ----------------------------------------------------------------------
  task automatic run_request(input logic [31:0] va, input logic we, input logic [31:0] wd,
                             input logic fm, input logic inh, input logic vm,
                             input logic tlb_op, output logic [31:0] rd, output int lat,
                             output int dlt, output logic flt);
    logic [7:0]  tidx;
    logic [31:0] pa;
    logic        exp_fault;
    logic        exp_hit;
    logic        exp_port;
    logic [31:0] exp_data;
    int          txn_before;
    int          busy_low;
    tidx      = va[15:8];
    exp_fault = !tlb_op && vm && (tlb_v[tidx] != va[31:16]);
    pa        = {(vm ? tlb_p[tidx] : va[31:16]), va[15:0]};
    exp_hit   = !tlb_op && !exp_fault && !we && !fm && !inh && line_resident(pa);
    exp_port  = !tlb_op && !exp_fault && !exp_hit;
    exp_data  = exp_hit ? c_data[pa[7:0]] : stored_word(pa);
    txn_before = txn_cnt;
    busy_low   = 0;
    req_count++;

    @(posedge CPU_CLK);
    cpu_valid           <= !tlb_op;
    tlb_we              <= tlb_op;
    cpu_req.addr        <= va;
    cpu_req.wdata       <= wd;
    cpu_req.we          <= we;
    cpu_req.force_miss  <= fm;
    vmem                <= vm;
    cache_inhibit       <= inh;
    @(posedge CPU_CLK);   // accept edge
    cpu_valid <= 1'b0;
    tlb_we    <= 1'b0;
    lat = 0;
    do
    begin
      @(negedge CPU_CLK);
      lat++;
      if (cpu_busy !== 1'b1)
        busy_low++;   // busy holds from lookup through the done cycle
    end
    while (cpu_done !== 1'b1);

    rd  = cpu_rdata;
    flt = cpu_fault;
    dlt = txn_cnt - txn_before;
    if (busy_low != 0)
      report_mismatch("cpu_busy low cycles", 0, busy_low);
    if (flt !== exp_fault)
      report_mismatch("cpu_fault", exp_fault, flt);
    if (dlt != int'(exp_port))
      report_mismatch("port transactions", exp_port, dlt);
    if (!exp_port && lat != 2)
      report_mismatch("latency", 2, lat);
    if (exp_port && dlt == 1)
    begin
      if (last_addr !== pa)
        report_mismatch("port address", pa, last_addr);
      if (last_we !== we)
        report_mismatch("port we", we, last_we);
      if (we && last_wdata !== wd)
        report_mismatch("port wdata", wd, last_wdata);
      if (last_dma !== (pa[31:30] == 2'b11))
        report_mismatch("dma port used", pa[31:30] == 2'b11, last_dma);
      if (last_dma && last_dma_we !== we)
        report_mismatch("dma_wrte strobe", we, last_dma_we);
    end
    if (!tlb_op && !exp_fault && !we && rd !== exp_data)
      report_mismatch("read data", exp_data, rd);

    if (tlb_op)
    begin
      tlb_p[tidx] = wd[31:16];
      tlb_v[tidx] = wd[15:0];
    end
    if (exp_port && we)
      store_word(pa, wd);
    if (exp_port && (we || !inh))   // stores always refresh the line
    begin
      c_valid[pa[7:0]] = 1'b1;
      c_tag[pa[7:0]]   = pa[31:8];
      c_data[pa[7:0]]  = we ? wd : exp_data;
    end
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic check_reset_state();
    start_test("reset_state");
    @(negedge CPU_CLK);
    if ({cpu_busy, cpu_done, cpu_fault, mem_valid, dma_wrte, dma_read} !== 6'b0)
      report_mismatch("idle outputs", 6'b0,
                      {cpu_busy, cpu_done, cpu_fault, mem_valid, dma_wrte, dma_read});
    end_test();
  endtask

  task automatic load_tlb();
    logic [31:0] va;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("tlb_load");
    for (int i = 0; i < tlb_cnt; i++)
    begin
      va       = $urandom;
      va[15:8] = i;
      run_request(va, 1'b0, $urandom, 1'b0, 1'b0, 1'b0, 1'b1, rd, lat, dlt, flt);
    end
    end_test();
  endtask

  task automatic fill_then_hit();
    logic [31:0] va;
    logic [31:0] rd1;
    logic [31:0] rd2;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("read_fill_hit");
    for (int i = 0; i < n_iter; i++)
    begin
      va = $urandom;
      run_request(va, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, rd1, lat, dlt, flt);
      run_request(va, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, rd2, lat, dlt, flt);
      if (rd2 !== rd1)
        report_mismatch("repeat data", rd1, rd2);
      if (lat != 2)
        report_mismatch("repeat latency", 2, lat);
      if (dlt != 0)
        report_mismatch("repeat port transactions", 0, dlt);
    end
    end_test();
  endtask

  task automatic write_then_read();
    logic [31:0] va;
    logic [31:0] wd;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("write_through");
    for (int i = 0; i < n_iter; i++)
    begin
      va = $urandom;
      wd = $urandom;
      run_request(va, 1'b1, wd, 1'b0, $urandom_range(1, 0), 1'b0, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1 || last_addr !== va || last_wdata !== wd)
        report_mismatch("store on port", wd, last_wdata);
      run_request(va, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, rd, lat, dlt, flt);
      if (rd !== wd)
        report_mismatch("read after write", wd, rd);
      if (dlt != 0)
        report_mismatch("read after write port transactions", 0, dlt);
    end
    end_test();
  endtask

  task automatic translate_pages();
    logic [7:0]  tidx;
    logic [31:0] va;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("translate");
    for (int i = 0; i < n_iter; i++)
    begin
      tidx = $urandom_range(tlb_cnt - 1, 0);
      va   = {tlb_v[tidx], tidx, 8'($urandom)};
      // reads use force_miss so the port always sees them
      run_request(va, i[0], $urandom, !i[0], 1'b0, 1'b1, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1)
        report_mismatch("port transactions", 1, dlt);
      else if (last_addr[31:16] !== tlb_p[tidx])
        report_mismatch("physical tag", tlb_p[tidx], last_addr[31:16]);
    end
    end_test();
  endtask

  task automatic fault_on_mismatch();
    logic [7:0]  tidx;
    logic [15:0] flip;
    logic [31:0] va;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("fault");
    for (int i = 0; i < n_iter; i++)
    begin
      tidx = $urandom_range(tlb_cnt - 1, 0);
      flip = $urandom_range(65535, 1);
      va   = {tlb_v[tidx] ^ flip, tidx, 8'($urandom)};
      run_request(va, i[0], $urandom, 1'b0, 1'b0, 1'b1, 1'b0, rd, lat, dlt, flt);
      if (flt !== 1'b1)
        report_mismatch("cpu_fault", 1'b1, flt);
      if (lat != 2)
        report_mismatch("fault latency", 2, lat);
      if (dlt != 0)
        report_mismatch("fault port transactions", 0, dlt);
    end
    end_test();
  endtask

  task automatic bypass_cache();
    logic [31:0] va;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("bypass");
    for (int i = 0; i < n_iter; i++)
    begin
      va = $urandom;
      run_request(va, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, rd, lat, dlt, flt);
      run_request(va, 1'b0, '0, 1'b1, 1'b0, 1'b0, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1)
        report_mismatch("force_miss port transactions", 1, dlt);
      run_request(va, 1'b0, '0, 1'b0, 1'b1, 1'b0, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1)
        report_mismatch("inhibit port transactions", 1, dlt);
      // a line that is not resident must stay out after an inhibited read
      do
        va = $urandom;
      while (line_resident(va));
      run_request(va, 1'b0, '0, 1'b0, 1'b1, 1'b0, 1'b0, rd, lat, dlt, flt);
      run_request(va, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1)
        report_mismatch("read after inhibit port transactions", 1, dlt);
    end
    end_test();
  endtask

  task automatic route_to_dma();
    logic [31:0] va;
    logic [31:0] rd;
    int          lat;
    int          dlt;
    logic        flt;
    start_test("dma_region");
    for (int i = 0; i < n_iter; i++)
    begin
      va        = $urandom;
      va[31:30] = 2'b11;
      run_request(va, i[0], $urandom, 1'b1, 1'b0, 1'b0, 1'b0, rd, lat, dlt, flt);
      if (dlt != 1)
        report_mismatch("port transactions", 1, dlt);
      else if (last_dma !== 1'b1)
        report_mismatch("dma port used", 1'b1, last_dma);
    end
    end_test();
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    seed = 32'hca1f80f7;
    void'($urandom(seed));
    CPU_CLK       = 1'b0;
    arst_n        <= 1'b0;
    cpu_valid     <= 1'b0;
    tlb_we        <= 1'b0;
    cpu_req       <= '0;
    vmem          <= 1'b0;
    cache_inhibit <= 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    req_count     = 0;
    for (int i = 0; i < line_cnt; i++)
      c_valid[i] = 1'b0;   // reset clears every line
    repeat (3) @(posedge CPU_CLK);
    arst_n <= 1'b1;

    check_reset_state();
    load_tlb();
    fill_then_hit();
    write_then_read();
    translate_pages();
    fault_on_mismatch();
    bypass_cache();
    route_to_dma();

    $display("tests %0d, failed %0d, requests %0d, errors %0d",
             tests_run, tests_failed, req_count, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    repeat (total_req * 20) @(posedge CPU_CLK);
    $display("watchdog expired after %0d cycles, a request never finished",
             total_req * 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verif/snow_mem_model.sv */
module snow_mem_model
  import snow_pkg::*;
(
  input  logic              CPU_CLK,
  input  logic              arst_n,
  input  port_req_t         port_req,
  input  logic              mem_valid,
  output logic              mem_ack,
  output logic [data_w-1:0] mem_rdata,
  input  logic              dma_wrte,
  input  logic              dma_read,
  output logic              dma_wrte_ack,
  output logic              dma_read_ack,
  output logic [data_w-1:0] dma_rdata,
  // last finished transaction, for the testbench checks
  output int                txn_cnt,
  output logic [addr_w-1:0] last_addr,
  output logic [data_w-1:0] last_wdata,
  output logic              last_we,
  output logic              last_dma,
  output logic              last_dma_we
);

  logic [addr_w-1:0] st_addr [$];   // sparse store, written words only
  logic [data_w-1:0] st_data [$];
  logic              active;
  logic              hold;          // request drops on this edge
  int unsigned       delay_left;

  // untouched words read back a pattern of their address
  function automatic logic [data_w-1:0] init_word(input logic [addr_w-1:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5ac3_e10f;
  endfunction

  function automatic logic [data_w-1:0] read_word(input logic [addr_w-1:0] a);
    foreach (st_addr[i])
      if (st_addr[i] == a)
        return st_data[i];
    return init_word(a);
  endfunction

  task automatic write_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    foreach (st_addr[i])
    begin
      if (st_addr[i] == a)
      begin
        st_data[i] = d;
        return;
      end
    end
    st_addr.push_back(a);
    st_data.push_back(d);
  endtask

  // ----------------------------------------------------------------------
  // ack after 1 to 6 cycles, one transaction at a time
  // ----------------------------------------------------------------------
  always @(posedge CPU_CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      active       <= 1'b0;
      hold         <= 1'b0;
      delay_left   <= 0;
      mem_ack      <= 1'b0;
      dma_wrte_ack <= 1'b0;
      dma_read_ack <= 1'b0;
      mem_rdata    <= '0;
      dma_rdata    <= '0;
      txn_cnt      <= 0;
      last_addr    <= '0;
      last_wdata   <= '0;
      last_we      <= 1'b0;
      last_dma     <= 1'b0;
      last_dma_we  <= 1'b0;
    end
    else
    begin
      mem_ack      <= 1'b0;
      dma_wrte_ack <= 1'b0;
      dma_read_ack <= 1'b0;
      if (active)
      begin
        if (delay_left == 0)
        begin
          active       <= 1'b0;
          hold         <= 1'b1;
          mem_ack      <= mem_valid;
          dma_wrte_ack <= dma_wrte;
          dma_read_ack <= dma_read;
          if (port_req.we)
            write_word(port_req.addr, port_req.wdata);
          // the port that was not asked returns the inverted word
          mem_rdata    <= mem_valid ? read_word(port_req.addr) : ~read_word(port_req.addr);
          dma_rdata    <= mem_valid ? ~read_word(port_req.addr) : read_word(port_req.addr);
          txn_cnt      <= txn_cnt + 1;
          last_addr    <= port_req.addr;
          last_wdata   <= port_req.wdata;
          last_we      <= port_req.we;
          last_dma     <= dma_wrte | dma_read;
          last_dma_we  <= dma_wrte;
        end
        else
          delay_left <= delay_left - 1;
      end
      else if (hold)
        hold <= 1'b0;   // controller drops its request here
      else if (mem_valid | dma_wrte | dma_read)
      begin
        active     <= 1'b1;
        delay_left <= $urandom_range(5, 0);
      end
    end
  end

endmodule
